// ==== all.f ====
+incdir+.
busPkg.sv
videoPkg.sv
spriteWriter.sv
lineBufferRam.sv
fixPixelStage.sv
pixelPriority.sv
watchdogTimer.sv
lineMixerTop.sv
tbLineMixer.sv

// ==== busPkg.sv ====
// CPU and palette bus types
`default_nettype none

package busPkg;

	// Palette RAM address as seen on PA
	typedef logic [11:0] palAddr_t;

	// Decoded upper CPU address bits
	typedef logic [1:0] cpuRegion_t;

	// Black during blanking
	localparam palAddr_t PA_BLANK = '0;

	// Fix entries live in the lowest palette bank
	localparam logic [3:0] FIX_BANK = 4'b0000;

endpackage

`default_nettype wire

// ==== fixPixelStage.sv ====
// Fix layer pixel stage
`timescale 1ns/1ps
`default_nettype none

module fixPixelStage import videoPkg::*;
(
	input wire CK1,
	input wire rstN,
	input wire fixLoad,
	input wire [7:0] fixData,
	input wire fixPal_t fixPalette,
	input wire fixHalf,
	input wire pixelStrobe,
	output color_t fixColor,
	output fixPal_t fixPalOut
);

	logic [7:0] fixPair;
	fixPal_t fixPalReg;
	color_t fixSel;

	// Two pixels per fetch
	always_ff @(posedge CK1 or negedge rstN)
	begin
		if (!rstN)
		begin
			fixPair <= '0;
			fixPalReg <= '0;
		end
		else if (fixLoad)
		begin
			fixPair <= fixData;
			fixPalReg <= fixPalette;
		end
	end

	// Odd or even pixel of the pair
	assign fixSel = fixHalf ? fixPair[7:4] : fixPair[3:0];

	// Same latency as the line buffer read
	always_ff @(posedge CK1 or negedge rstN)
	begin
		if (!rstN)
		begin
			fixColor <= '0;
			fixPalOut <= '0;
		end
		else if (pixelStrobe)
		begin
			fixColor <= fixSel;
			fixPalOut <= fixPalReg;
		end
	end

endmodule

`default_nettype wire

// ==== lineBufferRam.sv ====
// Clear-on-read line buffer
`timescale 1ns/1ps
`default_nettype none

`include "lineMixer_cfg.svh"

module lineBufferRam import videoPkg::*;
(
	input wire CK1,
	input wire wrEn,
	input wire lbAddr_t wrAddr,
	input wire lbEntry_t wrData,
	input wire rdEn,
	input wire lbAddr_t rdAddr,
	output lbEntry_t rdData
);

	lbEntry_t mem [`LB_DEPTH];

	// Power up empty
	initial
	begin
		for (int i = 0; i < `LB_DEPTH; i++)
			mem[i] = LB_EMPTY;
		rdData = LB_EMPTY;
	end

	// Render side
	always @(posedge CK1)
	begin
		if (wrEn)
			mem[wrAddr] <= wrData;
	end

	// Display side, slot is wiped once shown
	always @(posedge CK1)
	begin
		if (rdEn)
		begin
			rdData <= mem[rdAddr];
			mem[rdAddr] <= LB_EMPTY;
		end
	end

endmodule

`default_nettype wire

// ==== lineMixerTop.sv ====
// Sprite line buffer and palette mixer
`timescale 1ns/1ps
`default_nettype none

module lineMixerTop import videoPkg::*, busPkg::*;
(
	input wire CK1,
	input wire rstN,
	// Sprite renderer
	input wire sprLoad,
	input wire palLoad,
	input wire sprValid,
	input wire lbAddr_t sprAddr,
	input wire sprPal_t sprPalette,
	input wire color_t sprColor,
	input wire bufSel,
	// Display timing
	input wire lineStart,
	input wire pixelStrobe,
	input wire blank,
	input wire frameStrobe,
	// Fix layer
	input wire fixLoad,
	input wire [7:0] fixData,
	input wire fixPal_t fixPalette,
	input wire fixHalf,
	// CPU side
	input wire asStart,
	input wire asEnd,
	input wire cpuWrite,
	input wire cpuRegion_t cpuRegion,
	input wire palAddr_t cpuAddrLow,
	output palAddr_t pa,
	output logic resetOutN,
	output logic haltN
);

	logic wrEn0;
	logic wrEn1;
	lbAddr_t wrAddr;
	lbEntry_t wrData;
	logic rdEn0;
	logic rdEn1;
	lbAddr_t rdAddr;
	lbEntry_t rdData0;
	lbEntry_t rdData1;
	color_t fixColor;
	fixPal_t fixPalOut;

	spriteWriter u_spriteWriter (
		.CK1(CK1), .rstN(rstN),
		.sprLoad(sprLoad), .palLoad(palLoad), .sprValid(sprValid),
		.sprAddr(sprAddr), .sprPalette(sprPalette), .sprColor(sprColor),
		.bufSel(bufSel),
		.wrEn0(wrEn0), .wrEn1(wrEn1), .wrAddr(wrAddr), .wrData(wrData)
	);

	// Ping-pong pair, shared write and read address
	lineBufferRam buf0 (
		.CK1(CK1),
		.wrEn(wrEn0), .wrAddr(wrAddr), .wrData(wrData),
		.rdEn(rdEn0), .rdAddr(rdAddr), .rdData(rdData0)
	);

	lineBufferRam buf1 (
		.CK1(CK1),
		.wrEn(wrEn1), .wrAddr(wrAddr), .wrData(wrData),
		.rdEn(rdEn1), .rdAddr(rdAddr), .rdData(rdData1)
	);

	fixPixelStage u_fixPixelStage (
		.CK1(CK1), .rstN(rstN),
		.fixLoad(fixLoad), .fixData(fixData), .fixPalette(fixPalette),
		.fixHalf(fixHalf), .pixelStrobe(pixelStrobe),
		.fixColor(fixColor), .fixPalOut(fixPalOut)
	);

	pixelPriority u_pixelPriority (
		.CK1(CK1), .rstN(rstN),
		.lineStart(lineStart), .pixelStrobe(pixelStrobe), .blank(blank),
		.bufSel(bufSel),
		.rdEn0(rdEn0), .rdEn1(rdEn1), .rdAddr(rdAddr),
		.rdData0(rdData0), .rdData1(rdData1),
		.fixColor(fixColor), .fixPalOut(fixPalOut),
		.asStart(asStart), .asEnd(asEnd),
		.cpuRegion(cpuRegion), .cpuAddrLow(cpuAddrLow),
		.pa(pa)
	);

	watchdogTimer u_watchdogTimer (
		.CK1(CK1), .rstN(rstN),
		.cpuWrite(cpuWrite), .cpuRegion(cpuRegion), .frameStrobe(frameStrobe),
		.resetOutN(resetOutN), .haltN(haltN)
	);

endmodule

`default_nettype wire

// ==== lineMixer_cfg.svh ====
// Line mixer configuration
`ifndef LINEMIXER_CFG_SVH
`define LINEMIXER_CFG_SVH

// Line buffer geometry
// 256 pixels per line
`define LB_ADDR_W 8
`define LB_DEPTH (1 << `LB_ADDR_W)

// Watchdog timing in frames
// Frames without a kick before firing
`define WDOG_FRAMES 8
// Frames the reset stays asserted
`define WDOG_HOLD 2

// Decoded upper CPU address codes
// Palette RAM takes over the PA bus
`define REGION_PALETTE 2'b10
// Writes here kick the watchdog
`define REGION_WATCHDOG 2'b11

`endif

// ==== pixelPriority.sv ====
// Pixel priority and PA mux
`timescale 1ns/1ps
`default_nettype none

`include "lineMixer_cfg.svh"

module pixelPriority import videoPkg::*, busPkg::*;
(
	input wire CK1,
	input wire rstN,
	input wire lineStart,
	input wire pixelStrobe,
	input wire blank,
	input wire bufSel,
	output logic rdEn0,
	output logic rdEn1,
	output lbAddr_t rdAddr,
	input wire lbEntry_t rdData0,
	input wire lbEntry_t rdData1,
	input wire color_t fixColor,
	input wire fixPal_t fixPalOut,
	input wire asStart,
	input wire asEnd,
	input wire cpuRegion_t cpuRegion,
	input wire palAddr_t cpuAddrLow,
	output palAddr_t pa
);

	lbAddr_t rdCnt;
	logic dispSelQ;
	logic blankQ;
	logic validQ;
	logic cpuAccess;
	lbEntry_t sprEntry;
	palAddr_t paMix;
	palAddr_t paVideo;

	// Line start restarts at pixel 0 even with a strobe
	assign rdAddr = lineStart ? '0 : rdCnt;

	// Display buffer is the one not being rendered
	assign rdEn0 = pixelStrobe && bufSel;
	assign rdEn1 = pixelStrobe && !bufSel;

	always_ff @(posedge CK1 or negedge rstN)
	begin
		if (!rstN)
			rdCnt <= '0;
		else if (pixelStrobe)
			rdCnt <= rdAddr + 1'b1;
		else if (lineStart)
			rdCnt <= '0;
	end

	// Track the read one cycle, until data is back
	always_ff @(posedge CK1 or negedge rstN)
	begin
		if (!rstN)
		begin
			dispSelQ <= 1'b0;
			blankQ <= 1'b0;
			validQ <= 1'b0;
		end
		else
		begin
			dispSelQ <= !bufSel;
			blankQ <= blank;
			validQ <= pixelStrobe;
		end
	end

	// Sprite data from whichever buffer was read
	assign sprEntry = dispSelQ ? rdData1 : rdData0;

	// Blank first, then opaque fix, sprites last
	always_comb
	begin
		if (blankQ)
			paMix = PA_BLANK;
		else if (fixColor != '0)
			paMix = {FIX_BANK, fixPalOut, fixColor};
		else
			paMix = {sprEntry.pal, sprEntry.color};
	end

	// Holds the last pixel between strobes
	always_ff @(posedge CK1 or negedge rstN)
	begin
		if (!rstN)
			paVideo <= PA_BLANK;
		else if (validQ)
			paVideo <= paMix;
	end

	// Address strobe decides who owns the bus
	always_ff @(posedge CK1 or negedge rstN)
	begin
		if (!rstN)
			cpuAccess <= 1'b0;
		else if (asStart)
			cpuAccess <= (cpuRegion == `REGION_PALETTE);
		else if (asEnd)
			cpuAccess <= 1'b0;
	end

	// CPU wins over video
	assign pa = cpuAccess ? cpuAddrLow : paVideo;

endmodule

`default_nettype wire

// ==== spriteWriter.sv ====
// Sprite line buffer writer
`timescale 1ns/1ps
`default_nettype none

module spriteWriter import videoPkg::*;
(
	input wire CK1,
	input wire rstN,
	input wire sprLoad,
	input wire palLoad,
	input wire sprValid,
	input wire lbAddr_t sprAddr,
	input wire sprPal_t sprPalette,
	input wire color_t sprColor,
	input wire bufSel,
	output logic wrEn0,
	output logic wrEn1,
	output lbAddr_t wrAddr,
	output lbEntry_t wrData
);

	sprPal_t palReg;
	lbAddr_t wrCnt;
	lbAddr_t curAddr;
	logic opaque;

	// A load in the same cycle as a pixel places that pixel
	assign curAddr = sprLoad ? sprAddr : wrCnt;

	// Colour 0 is a hole in the sprite
	assign opaque = sprValid && (sprColor != '0);

	// Write address and payload
	assign wrAddr = curAddr;
	assign wrData.pal = palReg;
	assign wrData.color = sprColor;

	// Steer into the buffer being rendered
	assign wrEn0 = opaque && !bufSel;
	assign wrEn1 = opaque && bufSel;

	// Palette of the current sprite
	always_ff @(posedge CK1 or negedge rstN)
	begin
		if (!rstN)
			palReg <= '0;
		else if (palLoad)
			palReg <= sprPalette;
	end

	// Load or count, transparent pixels still advance
	always_ff @(posedge CK1 or negedge rstN)
	begin
		if (!rstN)
			wrCnt <= '0;
		else if (sprValid)
			wrCnt <= curAddr + 1'b1;
		else if (sprLoad)
			wrCnt <= sprAddr;
	end

endmodule

`default_nettype wire

// ==== tbLineMixer.sv ====
// Line mixer testbench
`timescale 1ns/1ps
`default_nettype none

`include "lineMixer_cfg.svh"

module tbLineMixer import videoPkg::*, busPkg::*;
();

	// Roughly four times the stimulus length
	localparam int CYCLE_LIMIT = 4000;

	logic CK1;
	logic rstN;
	logic sprLoad;
	logic palLoad;
	logic sprValid;
	lbAddr_t sprAddr;
	sprPal_t sprPalette;
	color_t sprColor;
	logic bufSel;
	logic lineStart;
	logic pixelStrobe;
	logic blank;
	logic frameStrobe;
	logic fixLoad;
	logic [7:0] fixData;
	fixPal_t fixPalette;
	logic fixHalf;
	logic asStart;
	logic asEnd;
	logic cpuWrite;
	cpuRegion_t cpuRegion;
	palAddr_t cpuAddrLow;
	palAddr_t pa;
	logic resetOutN;
	logic haltN;

	// Reference model of both line buffers
	logic [11:0] lineRef [0:1][0:`LB_DEPTH-1];
	lbAddr_t rdPos;
	logic [7:0] fixPairRef;
	fixPal_t fixPalRef;

	// Expected PA, delayed to the cycle it shows up
	palAddr_t expNow;
	palAddr_t expD1;
	palAddr_t expD2;
	logic strbD1;
	logic strbD2;
	logic expCpu;

	int errors;
	int pixels;
	int cycles;

	lineMixerTop u_lineMixerTop (.*);

	initial
	begin
		CK1 = 1'b0;
		forever #4 CK1 = ~CK1;
	end

	// Run limit
	always @(posedge CK1)
	begin
		cycles++;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Regression failed");
			$finish;
		end
	end

	// Pixel result is due two cycles after its strobe
	always @(posedge CK1 or negedge rstN)
	begin
		if (!rstN)
		begin
			strbD1 <= 1'b0;
			strbD2 <= 1'b0;
			expD1 <= '0;
			expD2 <= '0;
		end
		else
		begin
			strbD1 <= pixelStrobe;
			strbD2 <= strbD1;
			expD1 <= expNow;
			expD2 <= expD1;
		end
	end

	// CPU owns PA from a palette address strobe until its end
	always @(posedge CK1 or negedge rstN)
	begin
		if (!rstN)
			expCpu <= 1'b0;
		else if (asStart)
			expCpu <= (cpuRegion == `REGION_PALETTE);
		else if (asEnd)
			expCpu <= 1'b0;
	end

	// Video pixel on PA
	assert property (@(posedge CK1) disable iff (!rstN) strbD2 |-> (expCpu || pa == expD2))
	else
	begin
		errors++;
		$display("MISMATCH at %0t: video pa %h, expected %h", $time, $sampled(pa),
			$sampled(expD2));
	end

	// CPU address on PA
	assert property (@(posedge CK1) disable iff (!rstN) expCpu |-> pa == cpuAddrLow)
	else
	begin
		errors++;
		$display("MISMATCH at %0t: cpu pa %h, expected %h", $time, $sampled(pa),
			$sampled(cpuAddrLow));
	end

	// A third of the values are transparent
	function automatic color_t randomColor();
		return ($urandom % 3 == 0) ? 4'h0 : 4'($urandom_range(15, 1));
	endfunction

	task automatic dropPulses();
		sprLoad = 1'b0;
		palLoad = 1'b0;
		sprValid = 1'b0;
		lineStart = 1'b0;
		pixelStrobe = 1'b0;
		fixLoad = 1'b0;
		asStart = 1'b0;
		asEnd = 1'b0;
		cpuWrite = 1'b0;
		frameStrobe = 1'b0;
	endtask

	task automatic idleCycles(input int n);
		repeat (n)
		begin
			@(negedge CK1);
			dropPulses();
		end
	endtask

	task automatic setBuffer(input logic sel);
		@(negedge CK1);
		dropPulses();
		bufSel = sel;
	endtask

	// Palette and start address in one cycle, then one pixel per cycle
	task automatic writeRun(input lbAddr_t start, input int len, input sprPal_t pal);
		lbAddr_t addr;
		color_t col;
		addr = start;
		@(negedge CK1);
		dropPulses();
		sprLoad = 1'b1;
		sprAddr = start;
		palLoad = 1'b1;
		sprPalette = pal;
		for (int i = 0; i < len; i++)
		begin
			col = randomColor();
			@(negedge CK1);
			dropPulses();
			sprValid = 1'b1;
			sprColor = col;
			// Holes leave the old entry alone
			if (col != 4'h0)
				lineRef[bufSel][addr] = {pal, col};
			addr = addr + 1'b1;
		end
	endtask

	task automatic startLine();
		@(negedge CK1);
		dropPulses();
		lineStart = 1'b1;
		rdPos = '0;
	endtask

	task automatic loadFix(input logic [7:0] pair, input fixPal_t pal);
		@(negedge CK1);
		dropPulses();
		fixLoad = 1'b1;
		fixData = pair;
		fixPalette = pal;
		fixPairRef = pair;
		fixPalRef = pal;
	endtask

	// One display pixel and its expected palette address
	task automatic strobePixel(input logic blankIn, input logic halfIn);
		logic d;
		color_t fixCol;
		logic [11:0] entry;
		@(negedge CK1);
		dropPulses();
		// Display side is the buffer not being written
		d = !bufSel;
		entry = lineRef[d][rdPos];
		lineRef[d][rdPos] = 12'h000;
		fixCol = halfIn ? fixPairRef[7:4] : fixPairRef[3:0];
		if (blankIn)
			expNow = '0;
		else if (fixCol != 4'h0)
			expNow = {4'h0, fixPalRef, fixCol};
		else
			expNow = entry;
		pixelStrobe = 1'b1;
		blank = blankIn;
		fixHalf = halfIn;
		rdPos = rdPos + 1'b1;
		pixels++;
	endtask

	task automatic cpuStart(input cpuRegion_t region, input palAddr_t addr);
		@(negedge CK1);
		dropPulses();
		asStart = 1'b1;
		cpuRegion = region;
		cpuAddrLow = addr;
	endtask

	task automatic cpuEnd();
		@(negedge CK1);
		dropPulses();
		asEnd = 1'b1;
	endtask

	task automatic kickWatchdog(input cpuRegion_t region);
		@(negedge CK1);
		dropPulses();
		cpuWrite = 1'b1;
		cpuRegion = region;
	endtask

	task automatic pulseFrame();
		@(negedge CK1);
		dropPulses();
		frameStrobe = 1'b1;
		@(negedge CK1);
		dropPulses();
	endtask

	task automatic checkWatchdog(input logic expLevel, input int frameNo);
		assert (resetOutN === expLevel && haltN === expLevel)
		else
		begin
			errors++;
			$display("MISMATCH at %0t: frame %0d resetOutN %b haltN %b, expected %b",
				$time, frameNo, resetOutN, haltN, expLevel);
		end
	endtask

	initial
	begin
		rstN = 1'b0;
		dropPulses();
		sprAddr = '0;
		sprPalette = '0;
		sprColor = '0;
		bufSel = 1'b0;
		blank = 1'b0;
		fixData = '0;
		fixPalette = '0;
		fixHalf = 1'b0;
		cpuRegion = '0;
		cpuAddrLow = '0;
		errors = 0;
		pixels = 0;
		cycles = 0;
		rdPos = '0;
		fixPairRef = '0;
		fixPalRef = '0;
		expNow = '0;
		void'($urandom(29750));
		for (int b = 0; b < 2; b++)
			for (int a = 0; a < `LB_DEPTH; a++)
				lineRef[b][a] = 12'h000;
		repeat (3) @(negedge CK1);
		rstN = 1'b1;

		// Two random runs into buffer 0 that may overlap and wrap
		setBuffer(1'b0);
		writeRun(8'($urandom), 40, 8'($urandom));
		writeRun(8'($urandom), 30, 8'($urandom));
		setBuffer(1'b1);
		startLine();
		for (int i = 0; i < `LB_DEPTH; i++)
			strobePixel(1'b0, 1'b0);

		// Second pass over the same line
		startLine();
		for (int i = 0; i < `LB_DEPTH; i++)
			strobePixel(1'b0, 1'b0);

		// Fix pairs over a sprite run, both nibbles
		setBuffer(1'b0);
		writeRun(8'h00, 64, 8'($urandom));
		setBuffer(1'b1);
		startLine();
		for (int i = 0; i < 32; i++)
		begin
			loadFix({randomColor(), randomColor()}, 4'($urandom));
			strobePixel(1'b0, 1'b0);
			strobePixel(1'b0, 1'b1);
		end

		// Blanking while buffer 1 is on display
		writeRun(8'h00, 64, 8'($urandom));
		setBuffer(1'b0);
		loadFix({randomColor(), randomColor()}, 4'($urandom));
		startLine();
		for (int i = 0; i < 64; i++)
			strobePixel(1'($urandom), 1'($urandom));

		// CPU palette access during video
		loadFix(8'h96, 4'h7);
		startLine();
		cpuStart(`REGION_PALETTE, 12'($urandom));
		for (int i = 0; i < 8; i++)
		begin
			strobePixel(1'b0, 1'(i));
			cpuAddrLow = 12'($urandom);
		end
		cpuEnd();
		for (int i = 0; i < 6; i++)
			strobePixel(1'b0, 1'(i));
		// Another region leaves video on PA
		cpuStart(2'b01, 12'hFFF);
		for (int i = 0; i < 8; i++)
			strobePixel(1'b0, 1'(i));
		cpuEnd();
		idleCycles(4);

		// Starved watchdog fires, then releases
		for (int f = 1; f <= `WDOG_FRAMES + `WDOG_HOLD; f++)
		begin
			pulseFrame();
			checkWatchdog(f < `WDOG_FRAMES || f >= `WDOG_FRAMES + `WDOG_HOLD, f);
		end

		// Kick just before the limit
		for (int f = 1; f < `WDOG_FRAMES; f++)
		begin
			pulseFrame();
			checkWatchdog(1'b1, f);
		end
		kickWatchdog(`REGION_WATCHDOG);
		for (int f = 1; f < `WDOG_FRAMES; f++)
		begin
			pulseFrame();
			checkWatchdog(1'b1, f);
		end
		// Palette region write is no kick
		kickWatchdog(`REGION_PALETTE);
		pulseFrame();
		checkWatchdog(1'b0, `WDOG_FRAMES);
		for (int f = 1; f <= `WDOG_HOLD; f++)
		begin
			pulseFrame();
			checkWatchdog(f >= `WDOG_HOLD, `WDOG_FRAMES + f);
		end
		idleCycles(4);

		$display("Run complete: %0d pixels strobed, %0d errors", pixels, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== videoPkg.sv ====
// Video pixel types
`default_nettype none

`include "lineMixer_cfg.svh"

package videoPkg;

	// Pixel colour index, 0 is transparent
	typedef logic [3:0] color_t;

	// Fix layer palette number
	typedef logic [3:0] fixPal_t;

	// Sprite palette number
	typedef logic [7:0] sprPal_t;

	// Line buffer entry
	// Palette on top, colour below
	typedef struct packed {
		sprPal_t pal;
		color_t  color;
	} lbEntry_t;

	// Empty slot, nothing drawn here
	localparam lbEntry_t LB_EMPTY = '0;

	// Pixel position within a line
	typedef logic [`LB_ADDR_W-1:0] lbAddr_t;

endpackage

`default_nettype wire

// ==== watchdogTimer.sv ====
// Frame watchdog
`timescale 1ns/1ps
`default_nettype none

`include "lineMixer_cfg.svh"

module watchdogTimer import busPkg::*;
(
	input wire CK1,
	input wire rstN,
	input wire cpuWrite,
	input wire cpuRegion_t cpuRegion,
	input wire frameStrobe,
	output logic resetOutN,
	output logic haltN
);

	localparam int CNT_W = $clog2(`WDOG_FRAMES);

	logic [CNT_W-1:0] frameCnt;
	logic holding;
	logic kick;

	assign kick = cpuWrite && (cpuRegion == `REGION_WATCHDOG);

	// One counter, first for the timeout then for the hold
	always_ff @(posedge CK1 or negedge rstN)
	begin
		if (!rstN)
		begin
			frameCnt <= '0;
			holding <= 1'b0;
		end
		else if (!holding)
		begin
			if (kick)
				frameCnt <= '0;
			else if (frameStrobe)
			begin
				// Starved, fire at this frame
				if (frameCnt == CNT_W'(`WDOG_FRAMES - 1))
				begin
					frameCnt <= '0;
					holding <= 1'b1;
				end
				else
					frameCnt <= frameCnt + 1'b1;
			end
		end
		else if (frameStrobe)
		begin
			// Release and start counting again
			if (frameCnt == CNT_W'(`WDOG_HOLD - 1))
			begin
				frameCnt <= '0;
				holding <= 1'b0;
			end
			else
				frameCnt <= frameCnt + 1'b1;
		end
	end

	// Halt follows reset
	assign resetOutN = !holding;
	assign haltN = !holding;

endmodule

`default_nettype wire
